//--- verilog/pcs_rx_defs.svh
// ==============================
// Widths, lock thresholds and register map of the 10GBASE-R receive lane
// ==============================
`ifndef PCS_RX_DEFS_SVH
`define PCS_RX_DEFS_SVH

`define PCS_DATA_W      64
`define PCS_HDR_W       2
`define PCS_CNT_W       16
`define PCS_APB_ADDR_W  8
`define PCS_APB_DATA_W  32

// Block lock thresholds, in valid blocks
`define PCS_LOCK_GOOD   16
`define PCS_BAD_LIMIT   16
`define PCS_WINDOW      64

`define PCS_FIFO_DEPTH  8

`define PCS_REG_STATUS  8'h00
`define PCS_REG_BAD_HDR 8'h04
`define PCS_REG_DROP    8'h08
`define PCS_REG_CTRL    8'h0C

`endif

//--- verilog/pcs_rx_pkg.sv
// ==============================
// Shared types of the receive lane, imported by every block
// ==============================
`include "pcs_rx_defs.svh"

package pcs_rx_pkg;

    typedef logic [`PCS_DATA_W-1:0]     pcs_data_t;
    typedef logic [`PCS_HDR_W-1:0]      pcs_hdr_t;
    typedef logic [`PCS_CNT_W-1:0]      pcs_cnt_t;
    typedef logic [`PCS_APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`PCS_APB_DATA_W-1:0] apb_data_t;

    // One 66-bit block, sync header on top
    typedef struct packed {
        pcs_hdr_t  hdr;
        pcs_data_t data;
    } pcs_block_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        LOCK_SEARCH,
        LOCK_SLIP_WAIT,
        LOCK_LOCKED
    } lock_state_t;

endpackage

//--- verilog/rx_block_lock.sv
// ==============================
// Block lock engine; finds header alignment via gearbox slips
// and forwards registered blocks once locked
// ==============================
`timescale 1ns/1ps
`include "pcs_rx_defs.svh"

module rx_block_lock (
    input  logic                   gt_rxusrclk,
    input  logic                   gt_tx_reset,
    input  pcs_rx_pkg::pcs_data_t  serdes_rx_data,
    input  pcs_rx_pkg::pcs_hdr_t   serdes_rx_hdr,
    input  logic                   serdes_rx_valid,
    output logic                   serdes_rx_bitslip,
    output pcs_rx_pkg::pcs_block_t lock_blk,
    output logic                   lock_blk_valid,
    output logic                   block_lock,
    output logic                   lock_lost,
    output logic                   bad_hdr
);
    import pcs_rx_pkg::*;

    localparam int GOOD_W    = $clog2(`PCS_LOCK_GOOD + 1);
    localparam int BAD_W     = $clog2(`PCS_BAD_LIMIT + 1);
    localparam int WIN_W     = $clog2(`PCS_WINDOW);
    localparam int SLIP_HOLD = 4;
    localparam int SLIP_W    = $clog2(SLIP_HOLD);

    lock_state_t       state;
    logic [GOOD_W-1:0] good_cnt;
    logic [SLIP_W-1:0] slip_cnt;
    logic [WIN_W-1:0]  win_cnt;
    logic [BAD_W-1:0]  bad_cnt;
    logic              hdr_ok;

    // 01 and 10 are the only legal sync headers
    assign hdr_ok     = ^serdes_rx_hdr;
    assign block_lock = (state == LOCK_LOCKED);

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            state             <= LOCK_SEARCH;
            good_cnt          <= '0;
            slip_cnt          <= '0;
            win_cnt           <= '0;
            bad_cnt           <= '0;
            serdes_rx_bitslip <= 1'b0;
            lock_blk_valid    <= 1'b0;
            lock_lost         <= 1'b0;
            bad_hdr           <= 1'b0;
        end else begin
            serdes_rx_bitslip <= 1'b0;
            lock_lost         <= 1'b0;
            bad_hdr           <= serdes_rx_valid && !hdr_ok;
            lock_blk_valid    <= serdes_rx_valid && (state == LOCK_LOCKED);
            if (serdes_rx_valid) begin
                case (state)
                    LOCK_SEARCH: begin
                        if (!hdr_ok) begin
                            serdes_rx_bitslip <= 1'b1;
                            good_cnt          <= '0;
                            slip_cnt          <= '0;
                            state             <= LOCK_SLIP_WAIT;
                        end else if (good_cnt == GOOD_W'(`PCS_LOCK_GOOD - 1)) begin
                            win_cnt <= '0;
                            bad_cnt <= '0;
                            state   <= LOCK_LOCKED;
                        end else begin
                            good_cnt <= good_cnt + 1'b1;
                        end
                    end
                    LOCK_SLIP_WAIT: begin
                        // Give the gearbox time to settle after a slip
                        if (slip_cnt == SLIP_W'(SLIP_HOLD - 1)) begin
                            good_cnt <= '0;
                            state    <= LOCK_SEARCH;
                        end else begin
                            slip_cnt <= slip_cnt + 1'b1;
                        end
                    end
                    LOCK_LOCKED: begin
                        if (!hdr_ok && bad_cnt == BAD_W'(`PCS_BAD_LIMIT - 1)) begin
                            lock_lost <= 1'b1;
                            good_cnt  <= '0;
                            state     <= LOCK_SEARCH;
                        end else if (win_cnt == WIN_W'(`PCS_WINDOW - 1)) begin
                            // Window closed, start a fresh one
                            win_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            win_cnt <= win_cnt + 1'b1;
                            bad_cnt <= bad_cnt + BAD_W'(!hdr_ok);
                        end
                    end
                    default: state <= LOCK_SEARCH;
                endcase
            end
        end
    end

    always_ff @(posedge gt_rxusrclk) begin
        if (serdes_rx_valid) begin
            lock_blk.hdr  <= serdes_rx_hdr;
            lock_blk.data <= serdes_rx_data;
        end
    end

endmodule

//--- verilog/rx_block_fifo.sv
// ==============================
// Elastic buffer for scrambled blocks; drops and flags writes when full
// ==============================
`timescale 1ns/1ps
`include "pcs_rx_defs.svh"

module rx_block_fifo (
    input  logic                   gt_rxusrclk,
    input  logic                   gt_tx_reset,
    input  pcs_rx_pkg::pcs_block_t wr_blk,
    input  logic                   wr_valid,
    output pcs_rx_pkg::pcs_block_t rd_blk,
    output logic                   rd_valid,
    input  logic                   rd_pop,
    output logic                   drop
);
    import pcs_rx_pkg::*;

    localparam int DEPTH = `PCS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    pcs_block_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_blk   = mem[rd_ptr];
    assign pop      = rd_pop && rd_valid;
    // A pop in the same cycle frees the slot for a write
    assign push     = wr_valid && (!full || pop);

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop   <= 1'b0;
        end else begin
            drop <= wr_valid && !push;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge gt_rxusrclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_blk;
        end
    end

endmodule

//--- verilog/rx_descrambler.sv
// ==============================
// Self-synchronizing descrambler, x^58 + x^39 + 1, 64 bits per pop
// ==============================
`timescale 1ns/1ps
`include "pcs_rx_defs.svh"

module rx_descrambler (
    input  logic                   gt_rxusrclk,
    input  logic                   gt_tx_reset,
    input  pcs_rx_pkg::pcs_block_t in_blk,
    input  logic                   in_valid,
    output logic                   in_pop,
    input  logic                   bypass,
    output pcs_rx_pkg::pcs_block_t out_blk,
    output logic                   out_valid,
    input  logic                   out_ready
);
    import pcs_rx_pkg::*;

    localparam int TAP_A = 39;
    localparam int TAP_B = 58;
    localparam int EXT_W = `PCS_DATA_W + TAP_B;

    // Last 58 scrambled bits, bit 57 the most recent
    logic [TAP_B-1:0] scr_state;
    logic [EXT_W-1:0] ext;
    pcs_data_t        plain;

    // Scrambled history followed by the new payload, bit 0 first on the line
    assign ext = {in_blk.data, scr_state};

    always_comb begin
        for (int i = 0; i < `PCS_DATA_W; i++) begin
            plain[i] = ext[i + TAP_B] ^ ext[i + TAP_B - TAP_A] ^ ext[i];
        end
    end

    assign out_valid    = in_valid;
    assign in_pop       = in_valid && out_ready;
    assign out_blk.hdr  = in_blk.hdr;
    assign out_blk.data = bypass ? in_blk.data : plain;

    // Keep the state in step even in bypass
    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            scr_state <= '0;
        end else if (in_pop) begin
            scr_state <= ext[EXT_W-1:`PCS_DATA_W];
        end
    end

endmodule

//--- verilog/pcs_rx_regs.sv
// ==============================
// APB register block: lock status, error counters, bypass control
// ==============================
`timescale 1ns/1ps
`include "pcs_rx_defs.svh"

module pcs_rx_regs (
    input  logic                 gt_rxusrclk,
    input  logic                 gt_tx_reset,
    input  pcs_rx_pkg::apb_req_t apb_req,
    output pcs_rx_pkg::apb_rsp_t apb_rsp,
    input  logic                 block_lock,
    input  logic                 lock_lost,
    input  logic                 bad_hdr,
    input  logic                 fifo_drop,
    output logic                 bypass
);
    import pcs_rx_pkg::*;

    logic     access;
    logic     rd_status;
    logic     rd_bad;
    logic     rd_drop;
    logic     mapped;
    logic     lost_sticky;
    pcs_cnt_t bad_cnt;
    pcs_cnt_t drop_cnt;

    // Clear on read first, then count and hold at all ones
    function automatic pcs_cnt_t cnt_next(input pcs_cnt_t cnt, input logic inc,
                                          input logic clr);
        pcs_cnt_t base;
        base = clr ? '0 : cnt;
        if (inc && base != '1) begin
            return base + 1'b1;
        end
        return base;
    endfunction

    assign access    = apb_req.psel && apb_req.penable;
    assign rd_status = access && !apb_req.pwrite && apb_req.paddr == `PCS_REG_STATUS;
    assign rd_bad    = access && !apb_req.pwrite && apb_req.paddr == `PCS_REG_BAD_HDR;
    assign rd_drop   = access && !apb_req.pwrite && apb_req.paddr == `PCS_REG_DROP;
    assign mapped    = apb_req.paddr inside {`PCS_REG_STATUS, `PCS_REG_BAD_HDR,
                                             `PCS_REG_DROP, `PCS_REG_CTRL};

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !mapped;
        case (apb_req.paddr)
            `PCS_REG_STATUS:  apb_rsp.prdata = apb_data_t'({lost_sticky, block_lock});
            `PCS_REG_BAD_HDR: apb_rsp.prdata = apb_data_t'(bad_cnt);
            `PCS_REG_DROP:    apb_rsp.prdata = apb_data_t'(drop_cnt);
            `PCS_REG_CTRL:    apb_rsp.prdata = apb_data_t'(bypass);
            default:          apb_rsp.prdata = '0;
        endcase
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            lost_sticky <= 1'b0;
            bad_cnt     <= '0;
            drop_cnt    <= '0;
            bypass      <= 1'b0;
        end else begin
            // A new loss wins over a clearing read
            lost_sticky <= lock_lost || (lost_sticky && !rd_status);
            bad_cnt     <= cnt_next(bad_cnt, bad_hdr, rd_bad);
            drop_cnt    <= cnt_next(drop_cnt, fifo_drop, rd_drop);
            if (access && apb_req.pwrite && apb_req.paddr == `PCS_REG_CTRL) begin
                bypass <= apb_req.pwdata[0];
            end
        end
    end

endmodule

//--- verilog/pcs_rx_top.sv
// ==============================
// Receive lane top: lock engine, block buffer, descrambler, registers
// ==============================
`timescale 1ns/1ps

module pcs_rx_top (
    input  logic                   gt_rxusrclk,
    input  logic                   gt_tx_reset,
    input  pcs_rx_pkg::pcs_data_t  serdes_rx_data,
    input  pcs_rx_pkg::pcs_hdr_t   serdes_rx_hdr,
    input  logic                   serdes_rx_valid,
    output logic                   serdes_rx_bitslip,
    output pcs_rx_pkg::pcs_block_t out_blk,
    output logic                   out_valid,
    input  logic                   out_ready,
    input  pcs_rx_pkg::apb_req_t   apb_req,
    output pcs_rx_pkg::apb_rsp_t   apb_rsp,
    output logic                   block_lock
);
    import pcs_rx_pkg::*;

    pcs_block_t lock_blk;
    logic       lock_blk_valid;
    logic       lock_lost;
    logic       bad_hdr;
    pcs_block_t fifo_blk;
    logic       fifo_valid;
    logic       fifo_pop;
    logic       fifo_drop;
    logic       bypass;

    rx_block_lock u_lock (
        .gt_rxusrclk       (gt_rxusrclk),
        .gt_tx_reset       (gt_tx_reset),
        .serdes_rx_data    (serdes_rx_data),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .serdes_rx_valid   (serdes_rx_valid),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .lock_blk          (lock_blk),
        .lock_blk_valid    (lock_blk_valid),
        .block_lock        (block_lock),
        .lock_lost         (lock_lost),
        .bad_hdr           (bad_hdr)
    );

    // Blocks stay scrambled in the buffer
    rx_block_fifo u_fifo (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .wr_blk      (lock_blk),
        .wr_valid    (lock_blk_valid),
        .rd_blk      (fifo_blk),
        .rd_valid    (fifo_valid),
        .rd_pop      (fifo_pop),
        .drop        (fifo_drop)
    );

    rx_descrambler u_descr (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .in_blk      (fifo_blk),
        .in_valid    (fifo_valid),
        .in_pop      (fifo_pop),
        .bypass      (bypass),
        .out_blk     (out_blk),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    pcs_rx_regs u_regs (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .block_lock  (block_lock),
        .lock_lost   (lock_lost),
        .bad_hdr     (bad_hdr),
        .fifo_drop   (fifo_drop),
        .bypass      (bypass)
    );

endmodule

//--- test/pcs_rx_tb.sv
// ==============================
// Self-checking testbench for the receive lane
// Covers lock, descrambled data, overflow and the APB registers
// ==============================
`timescale 1ns/1ps
`include "pcs_rx_defs.svh"

module pcs_rx_tb;
    import pcs_rx_pkg::*;

    localparam int HALF  = 10;
    localparam int TAP_A = 39;
    localparam int TAP_B = 58;
    localparam int DEPTH = `PCS_FIFO_DEPTH;

    // One expected output block
    typedef struct packed {
        logic        chk_data;
        logic        chk_lat;
        logic [31:0] cyc;
        pcs_block_t  blk;
    } exp_t;

    logic       gt_rxusrclk = 1'b0;
    logic       gt_tx_reset;
    pcs_data_t  serdes_rx_data;
    pcs_hdr_t   serdes_rx_hdr;
    logic       serdes_rx_valid;
    logic       serdes_rx_bitslip;
    pcs_block_t out_blk;
    logic       out_valid;
    logic       out_ready;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       block_lock;

    int         seed = 68852;
    int         err_chk = 0;
    int         err_data = 0;
    int         err_prop = 0;
    int         err_timeout = 0;
    int         cyc = 0;
    int         bad_sent = 0;
    logic       resync;
    logic       bypass_on;
    logic [TAP_B-1:0] tx_sr;
    exp_t       exp_q[$];
    exp_t       mon_e;

    pcs_rx_top UUT (.*);

    always #HALF gt_rxusrclk = ~gt_rxusrclk;

    assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset) apb_rsp.pready)
        else begin
            err_prop++;
            $display("ERROR apb_rsp.pready exp 1 got %h", apb_rsp.pready);
        end
    assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        apb_rsp.pslverr |-> apb_req.psel && apb_req.penable)
        else begin
            err_prop++;
            $display("Slave error raised outside an APB access phase");
        end
    assert property (@(posedge gt_rxusrclk) disable iff (gt_tx_reset)
        !(serdes_rx_bitslip && block_lock))
        else begin
            err_prop++;
            $display("Gearbox slip requested while block lock is held");
        end

    // Output monitor pops one expected entry per accepted block
    always @(posedge gt_rxusrclk) begin
        cyc <= cyc + 1;
        if (!gt_tx_reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                err_data++;
                $display("A block came out that was never expected");
            end else begin
                mon_e = exp_q.pop_front();
                assert (out_blk.hdr === mon_e.blk.hdr) else begin
                    err_data++;
                    $display("ERROR out_blk.hdr exp %h got %h", mon_e.blk.hdr, out_blk.hdr);
                end
                assert (!mon_e.chk_data || out_blk.data === mon_e.blk.data) else begin
                    err_data++;
                    $display("ERROR out_blk.data exp %h got %h", mon_e.blk.data, out_blk.data);
                end
                assert (!mon_e.chk_lat || cyc == mon_e.cyc) else begin
                    err_data++;
                    $display("ERROR out_valid cycle exp %h got %h", mon_e.cyc, cyc);
                end
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            err_chk++;
            $display("ERROR %s exp %h got %h", name, exp, got);
        end
    endtask

    // Serial x^58 + x^39 + 1 scrambler sending bit 0 first
    task automatic scramble(input pcs_data_t plain, output pcs_data_t scr);
        logic s;
        for (int i = 0; i < `PCS_DATA_W; i++) begin
            s = plain[i] ^ tx_sr[TAP_A-1] ^ tx_sr[TAP_B-1];
            tx_sr = {tx_sr[TAP_B-2:0], s};
            scr[i] = s;
        end
    endtask

    task automatic send_blk(input pcs_hdr_t hdr, input logic fwd, input logic chk_lat);
        pcs_data_t plain;
        pcs_data_t scr;
        exp_t      e;
        plain = {$random(seed), $random(seed)};
        scramble(plain, scr);
        @(negedge gt_rxusrclk);
        serdes_rx_hdr   = hdr;
        serdes_rx_data  = scr;
        serdes_rx_valid = 1'b1;
        if (hdr == 2'b00 || hdr == 2'b11) begin
            bad_sent++;
        end
        if (fwd) begin
            e.blk.hdr  = hdr;
            e.blk.data = bypass_on ? scr : plain;
            // The raw payload does not depend on the descrambler state
            e.chk_data = bypass_on || !resync;
            e.chk_lat  = chk_lat;
            e.cyc      = cyc + 2;
            exp_q.push_back(e);
            resync = 1'b0;
        end
    endtask

    task automatic idle_cycle();
        @(negedge gt_rxusrclk);
        serdes_rx_valid = 1'b0;
    endtask

    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(negedge gt_rxusrclk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge gt_rxusrclk);
        apb_req.penable = 1'b1;
        // Sample mid access phase before the completing edge
        #(HALF / 2);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge gt_rxusrclk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic read_check(input apb_addr_t addr, input apb_data_t exp, input string name);
        apb_data_t rdata;
        logic      err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_val(name, rdata, exp);
        check_val("apb_rsp.pslverr", err, 1'b0);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            @(negedge gt_rxusrclk);
            n++;
        end
        if (exp_q.size() != 0) begin
            err_timeout++;
            $display("Timed out waiting for %0d expected blocks", exp_q.size());
        end
    endtask

    task automatic wait_unlock();
        int n;
        n = 0;
        while (block_lock && n < 50) begin
            @(negedge gt_rxusrclk);
            n++;
        end
        if (block_lock) begin
            err_timeout++;
            $display("Timed out waiting for block lock to drop");
        end
    endtask

    initial begin
        pcs_hdr_t  hdr;
        logic      exp_slip;
        int        slip_wait;
        apb_data_t rdata;
        logic      err;
        gt_tx_reset     = 1'b1;
        serdes_rx_data  = '0;
        serdes_rx_hdr   = '0;
        serdes_rx_valid = 1'b0;
        out_ready       = 1'b1;
        apb_req         = '0;
        resync          = 1'b1;
        bypass_on       = 1'b0;
        slip_wait       = 0;
        tx_sr           = TAP_B'({$random(seed), $random(seed)});
        repeat (4) @(posedge gt_rxusrclk);
        @(negedge gt_rxusrclk);
        gt_tx_reset = 1'b0;

        // Reset state
        check_val("out_valid", out_valid, 1'b0);
        check_val("serdes_rx_bitslip", serdes_rx_bitslip, 1'b0);
        check_val("block_lock", block_lock, 1'b0);
        check_val("apb_rsp.pslverr", apb_rsp.pslverr, 1'b0);
        read_check(`PCS_REG_STATUS, 0, "prdata STATUS");
        read_check(`PCS_REG_BAD_HDR, 0, "prdata BAD_HDR");
        read_check(`PCS_REG_DROP, 0, "prdata DROP");
        read_check(`PCS_REG_CTRL, 0, "prdata CTRL");

        // Invalid headers while searching slip only outside the wait
        for (int i = 0; i < 12; i++) begin
            hdr      = (($random(seed) & 1) != 0) ? 2'b11 : 2'b00;
            exp_slip = (slip_wait == 0);
            send_blk(hdr, 1'b0, 1'b0);
            slip_wait = exp_slip ? 4 : slip_wait - 1;
            idle_cycle();
            check_val("serdes_rx_bitslip", serdes_rx_bitslip, exp_slip);
            check_val("block_lock", block_lock, 1'b0);
        end
        repeat (slip_wait) send_blk(2'b01, 1'b0, 1'b0);
        for (int i = 0; i < `PCS_LOCK_GOOD; i++) begin
            send_blk((($random(seed) & 1) != 0) ? 2'b01 : 2'b10, 1'b0, 1'b0);
            check_val("block_lock", block_lock, 1'b0);
        end
        idle_cycle();
        check_val("block_lock", block_lock, 1'b1);

        // Descrambled data at full rate
        for (int i = 0; i < 12; i++) begin
            send_blk((($random(seed) & 1) != 0) ? 2'b01 : 2'b10, 1'b1, 1'b1);
        end
        idle_cycle();
        wait_drain();

        // Back-pressure fills the buffer and the last three are dropped
        @(negedge gt_rxusrclk);
        out_ready = 1'b0;
        for (int i = 0; i < DEPTH + 3; i++) begin
            send_blk((($random(seed) & 1) != 0) ? 2'b01 : 2'b10, i < DEPTH, 1'b0);
        end
        idle_cycle();
        resync = 1'b1;
        read_check(`PCS_REG_DROP, 3, "prdata DROP");
        read_check(`PCS_REG_DROP, 0, "prdata DROP");
        @(negedge gt_rxusrclk);
        out_ready = 1'b1;
        wait_drain();

        // Bypass passes the scrambled payload
        apb_xfer(1'b1, `PCS_REG_CTRL, 1, rdata, err);
        read_check(`PCS_REG_CTRL, 1, "prdata CTRL");
        bypass_on = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_blk((($random(seed) & 1) != 0) ? 2'b01 : 2'b10, 1'b1, 1'b0);
        end
        idle_cycle();
        wait_drain();
        apb_xfer(1'b1, `PCS_REG_CTRL, 0, rdata, err);
        bypass_on = 1'b0;
        apb_xfer(1'b0, 8'h10, 0, rdata, err);
        check_val("apb_rsp.pslverr", err, 1'b1);

        // Enough bad headers in one window to lose lock
        for (int i = 0; i < `PCS_BAD_LIMIT; i++) begin
            send_blk((($random(seed) & 1) != 0) ? 2'b11 : 2'b00, 1'b1, 1'b0);
        end
        idle_cycle();
        wait_unlock();
        wait_drain();
        read_check(`PCS_REG_STATUS, 2, "prdata STATUS");
        read_check(`PCS_REG_STATUS, 0, "prdata STATUS");
        read_check(`PCS_REG_BAD_HDR, bad_sent, "prdata BAD_HDR");

        $display("errors: checks %0d, data %0d, properties %0d, timeouts %0d",
                 err_chk, err_data, err_prop, err_timeout);
        if (err_chk + err_data + err_prop + err_timeout == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- pcs_rx_top.f
+incdir+verilog
verilog/pcs_rx_pkg.sv
verilog/rx_block_lock.sv
verilog/rx_block_fifo.sv
verilog/rx_descrambler.sv
verilog/pcs_rx_regs.sv
verilog/pcs_rx_top.sv
test/pcs_rx_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := pcs_rx_tb
FILELIST := pcs_rx_top.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
